// ==== countdown_matrix.f ====
src/matrix_pkg.sv
src/timer_pkg.sv
src/step_tick.sv
src/countdown_ctrl.sv
src/digit_matrix_scan.sv
src/countdown_matrix.sv
sim/countdown_matrix_props.sv
sim/tb_countdown_matrix.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_countdown_matrix
FILELIST  ?= countdown_matrix.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_countdown_matrix.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_countdown_matrix;

    import matrix_pkg::*;
    import timer_pkg::*;

    localparam int TICKS_PER_STEP = 20;
    localparam int START_VALUE    = 5;
    localparam int NUM_RUNS       = 6;
    localparam int RANDOM_CYCLES  = 50;
    // one forced and up to two random countdowns per run
    localparam int PLANNED_COUNTDOWNS = 3 * NUM_RUNS;
    localparam int DONE_TIMEOUT       = (START_VALUE + 2) * TICKS_PER_STEP;
    localparam longint WATCHDOG_NS =
        longint'(PLANNED_COUNTDOWNS + 2) * (START_VALUE + 1) * TICKS_PER_STEP * 10;

    logic          clk;
    logic          rst;
    logic          start;
    matrix_drive_t matrix;
    logic          done;

    int     errors;
    integer seed;

    // reference model
    ctrl_state_t   m_state;
    digit_t        m_digit;
    logic          m_done;
    int            m_phase;       // edges since last step boundary
    logic          m_tick;
    digit_t        m_digit_q;
    row_idx_t      m_row_idx;
    digit_t        shown_digit;   // digit behind the current column word
    matrix_drive_t exp_word;
    int            edges_after_reset;
    row_t          prev_row;
    int            countdowns_done;
    int            ignored_starts;
    int            restarts;

    // [digit][row]
    col_t glyph_tab [0:5][0:7] = '{
        '{8'h00, 8'h3c, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3c},
        '{8'h00, 8'h18, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h7e},
        '{8'h3c, 8'h66, 8'h06, 8'h0c, 8'h00, 8'h30, 8'h60, 8'h7e},
        '{8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c, 8'h00},
        '{8'h0c, 8'h1c, 8'h2c, 8'h4c, 8'h7e, 8'h0c, 8'h0c, 8'h00},
        '{8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c, 8'h00}
    };

    function automatic col_t red_cols(input digit_t d, input row_idx_t r);
        if (d >= 3'd2 && d <= 3'd5)
            return glyph_tab[d][r];
        return '0;
    endfunction

    function automatic col_t green_cols(input digit_t d, input row_idx_t r);
        if (d <= 3'd3)
            return glyph_tab[d][r];
        return '0;
    endfunction

    countdown_matrix #(
        .TICKS_PER_STEP(TICKS_PER_STEP),
        .START_VALUE   (START_VALUE)
    ) countdown_matrix_inst (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .matrix(matrix),
        .done  (done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_state = IDLE;
            m_digit = DIGIT_BLANK;
            m_done = 1'b0;
            m_phase = TICKS_PER_STEP - 1;   // free-running tick on first edge
            m_tick = 1'b0;
            m_digit_q = DIGIT_BLANK;
            m_row_idx = '0;
            shown_digit = DIGIT_BLANK;
            exp_word = '{row: '1, colr: '0, colg: '0};
            edges_after_reset = 0;
        end
        else
        begin
            exp_word.row = '1;
            exp_word.row[m_row_idx] = 1'b0;
            exp_word.colr = red_cols(m_digit_q, m_row_idx);
            exp_word.colg = green_cols(m_digit_q, m_row_idx);
            shown_digit = m_digit_q;
            m_row_idx = m_row_idx + 3'd1;
            m_digit_q = m_digit;
            if (m_state == COUNTING)
            begin
                if (start)
                    ignored_starts++;
                if (m_tick)
                begin
                    m_digit = m_digit - 3'd1;
                    if (m_digit == 3'd0)
                    begin
                        m_state = FINISHED;
                        m_done = 1'b1;
                        countdowns_done++;
                    end
                end
            end
            else if (start)
            begin
                if (m_state == FINISHED)
                    restarts++;
                m_state = COUNTING;
                m_digit = digit_t'(START_VALUE);
                m_done = 1'b0;
            end
            // start realigns the step boundary in every state
            if (start)
                m_phase = 0;
            else
                m_phase = (m_phase + 1) % TICKS_PER_STEP;
            m_tick = !start && (m_phase == 0);
            edges_after_reset++;
        end
    end

    always @(negedge clk)
    begin
        if (!rst)
        begin
            assert (matrix == exp_word)
            else
            begin
                $display("ERR %0t: matrix word %h, expected %h (digit %0d)",
                         $time, matrix, exp_word, shown_digit);
                errors++;
            end
            assert (done == m_done)
            else
            begin
                $display("ERR %0t: done is %b, expected %b", $time, done, m_done);
                errors++;
            end
            if (edges_after_reset > 0)
                assert ($countones(~matrix.row) == 1)
                else
                begin
                    $display("ERR %0t: row select %h not one low bit", $time, matrix.row);
                    errors++;
                end
            if (edges_after_reset > 1)
                assert (matrix.row == {prev_row[6:0], prev_row[7]})
                else
                begin
                    $display("ERR %0t: row %h does not follow %h", $time, matrix.row, prev_row);
                    errors++;
                end
            if (matrix.colr != '0)
                assert (shown_digit >= 3'd2 && shown_digit <= 3'd5)
                else
                begin
                    $display("ERR %0t: red lit for digit %0d", $time, shown_digit);
                    errors++;
                end
            if (matrix.colg != '0)
                assert (shown_digit <= 3'd3)
                else
                begin
                    $display("ERR %0t: green lit for digit %0d", $time, shown_digit);
                    errors++;
                end
            if (shown_digit == 3'd2 || shown_digit == 3'd3)
                assert (matrix.colr == matrix.colg)
                else
                begin
                    $display("ERR %0t: digit %0d not yellow", $time, shown_digit);
                    errors++;
                end
            prev_row = matrix.row;
        end
    end

    task automatic pulse_start();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < DONE_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        assert (done === 1'b1)
        else
        begin
            $display("done did not rise within %0d cycles of waiting", DONE_TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_countdown();
        int mid_wait;
        mid_wait = 30 + ({$random(seed)} % 50);
        if (m_state == COUNTING)
            wait_done();
        pulse_start();
        repeat (mid_wait) @(posedge clk);
        pulse_start();   // lands mid-count
        wait_done();
        repeat (5 + {$random(seed)} % 16) @(posedge clk);
    endtask

    task automatic random_phase(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #1 start = !start && ({$random(seed)} % 60 == 0);
        end
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    initial
    begin
        int run;
        errors = 0;
        seed = 92747;
        countdowns_done = 0;
        ignored_starts = 0;
        restarts = 0;
        prev_row = '1;
        start = 1'b0;
        rst = 1'b1;
        @(negedge clk);
        assert (matrix.row == 8'hff && matrix.colr == 8'h00 && matrix.colg == 8'h00
                && done == 1'b0)
        else
        begin
            $display("ERR %0t: outputs not in reset state, matrix %h done %b",
                     $time, matrix, done);
            errors++;
        end
        @(posedge clk);
        #1 rst = 1'b0;
        // first scan pass shows blank
        repeat (8)
        begin
            @(negedge clk);
            assert (matrix.colr == '0 && matrix.colg == '0)
            else
            begin
                $display("ERR %0t: columns lit before start, matrix %h", $time, matrix);
                errors++;
            end
        end
        for (run = 0; run < NUM_RUNS; run++)
        begin
            run_countdown();
            random_phase(RANDOM_CYCLES);
        end
        if (m_state == COUNTING)
            wait_done();
        repeat (10) @(negedge clk);
        errors += countdown_matrix_inst.digit_matrix_scan_inst.props_inst.fail_count;
        assert (countdowns_done >= NUM_RUNS && ignored_starts >= NUM_RUNS
                && restarts >= NUM_RUNS - 1)
        else
        begin
            $display("too few scenarios ran: %0d countdowns, %0d ignored, %0d restarts",
                     countdowns_done, ignored_starts, restarts);
            errors++;
        end
        $display("run finished with %0d errors", errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: countdown runs still going after %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/countdown_matrix_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module digit_matrix_scan_props (
    input logic                      clk,
    input logic                      rst,
    input matrix_pkg::digit_t        digit_q,
    input matrix_pkg::matrix_drive_t matrix
);

    import matrix_pkg::*;

    logic scanning;   // first word after reset written
    int   fail_count = 0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scanning <= 1'b0;
        else
            scanning <= 1'b1;
    end

    row_one_hot: assert property (
        @(posedge clk) disable iff (rst) scanning |-> $onehot(~matrix.row))
    else
    begin
        fail_count++;
        $error("row select does not have exactly one low bit");
    end

    // low bit walks up one row per clock
    row_rotates: assert property (
        @(posedge clk) disable iff (rst)
        scanning |=> matrix.row == row_t'({$past(matrix.row[6:0]), $past(matrix.row[7])}))
    else
    begin
        fail_count++;
        $error("row word is not the previous word rotated by one");
    end

    blank_dark: assert property (
        @(posedge clk) disable iff (rst)
        (digit_q >= 3'd6) |=> (matrix.colr == '0 && matrix.colg == '0))
    else
    begin
        fail_count++;
        $error("columns lit for a blank digit code");
    end

endmodule

bind digit_matrix_scan digit_matrix_scan_props props_inst (
    .clk    (clk),
    .rst    (rst),
    .digit_q(digit_q),
    .matrix (matrix)
);

`default_nettype wire

// ==== src/countdown_matrix.sv ====
`timescale 1ns/1ns
`default_nettype none

module countdown_matrix #(
    parameter int TICKS_PER_STEP = 1000,   // 1 s per digit at 1 kHz
    parameter int START_VALUE    = 5
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    output matrix_pkg::matrix_drive_t matrix,
    output logic                      done
);

    import timer_pkg::*;

    logic          tick;
    timer_status_t status;

    step_tick #(
        .TICKS_PER_STEP(TICKS_PER_STEP)
    ) step_tick_inst (
        .clk  (clk),
        .rst  (rst),
        .start(start),
        .tick (tick)
    );

    countdown_ctrl #(
        .START_VALUE(START_VALUE)
    ) countdown_ctrl_inst (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .tick  (tick),
        .status(status)
    );

    digit_matrix_scan digit_matrix_scan_inst (
        .clk   (clk),
        .rst   (rst),
        .digit (status.digit),
        .matrix(matrix)
    );

    assign done = status.done;

endmodule

`default_nettype wire

// ==== src/digit_matrix_scan.sv ====
`timescale 1ns/1ns
`default_nettype none

module digit_matrix_scan (
    input  logic                      clk,
    input  logic                      rst,
    input  matrix_pkg::digit_t        digit,
    output matrix_pkg::matrix_drive_t matrix
);

    import matrix_pkg::*;

    digit_t   digit_q;
    row_idx_t row_idx;

    // bitmap of one glyph row, colour applied separately
    function automatic col_t glyph_bits(input digit_t d, input row_idx_t r);
        col_t bits;
        bits = '0;
        case (d)
            3'd5:
                case (r)
                    3'd0:       bits = 8'b0111_1110;
                    3'd1:       bits = 8'b0110_0000;
                    3'd2:       bits = 8'b0111_1100;
                    3'd3, 3'd4: bits = 8'b0000_0110;
                    3'd5:       bits = 8'b0110_0110;
                    3'd6:       bits = 8'b0011_1100;
                    default:    bits = '0;
                endcase
            3'd4:
                case (r)
                    3'd0, 3'd5, 3'd6: bits = 8'b0000_1100;
                    3'd1:             bits = 8'b0001_1100;
                    3'd2:             bits = 8'b0010_1100;
                    3'd3:             bits = 8'b0100_1100;
                    3'd4:             bits = 8'b0111_1110;
                    default:          bits = '0;
                endcase
            3'd3:
                case (r)
                    3'd0, 3'd6: bits = 8'b0011_1100;
                    3'd1, 3'd5: bits = 8'b0110_0110;
                    3'd2, 3'd4: bits = 8'b0000_0110;
                    3'd3:       bits = 8'b0001_1100;
                    default:    bits = '0;
                endcase
            3'd2:
                case (r)
                    3'd0:    bits = 8'b0011_1100;
                    3'd1:    bits = 8'b0110_0110;
                    3'd2:    bits = 8'b0000_0110;
                    3'd3:    bits = 8'b0000_1100;
                    3'd5:    bits = 8'b0011_0000;
                    3'd6:    bits = 8'b0110_0000;
                    3'd7:    bits = 8'b0111_1110;
                    default: bits = '0;   // row 4 left dark
                endcase
            3'd1:
                case (r)
                    3'd1, 3'd2, 3'd4, 3'd5, 3'd6: bits = 8'b0001_1000;
                    3'd3:                         bits = 8'b0011_1000;
                    3'd7:                         bits = 8'b0111_1110;
                    default:                      bits = '0;
                endcase
            3'd0:
                case (r)
                    3'd1, 3'd7:                   bits = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5, 3'd6: bits = 8'b0100_0010;
                    default:                      bits = '0;
                endcase
            default: bits = '0;   // blank codes
        endcase
        return bits;
    endfunction

    // red for 5..2, green for 3..0, so 3 and 2 come out yellow
    function automatic logic shows_red(input digit_t d);
        return (d >= 3'd2) && (d <= 3'd5);
    endfunction

    function automatic logic shows_green(input digit_t d);
        return d <= 3'd3;
    endfunction

    // input digit held for a whole scan step
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            digit_q <= DIGIT_BLANK;
        else
            digit_q <= digit;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else
            row_idx <= row_idx + 1'b1;   // wraps 7 -> 0
    end

    // row and columns taken from the same index, so one word stays coherent
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            matrix.row  <= '1;   // nothing lit
            matrix.colr <= '0;
            matrix.colg <= '0;
        end
        else
        begin
            matrix.row <= ~(row_t'(1) << row_idx);
            if (shows_red(digit_q))
                matrix.colr <= glyph_bits(digit_q, row_idx);
            else
                matrix.colr <= '0;
            if (shows_green(digit_q))
                matrix.colg <= glyph_bits(digit_q, row_idx);
            else
                matrix.colg <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/countdown_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module countdown_ctrl #(
    parameter int START_VALUE = 5
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    tick,
    output timer_pkg::timer_status_t status
);

    import matrix_pkg::*;
    import timer_pkg::*;

    localparam digit_t FIRST_DIGIT = digit_t'(START_VALUE);

    ctrl_state_t state;
    digit_t      digit_q;
    logic        done_q;
    logic        start_ok;

    // restart allowed only when not already running
    assign start_ok = start && (state != COUNTING);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= IDLE;
            digit_q <= DIGIT_BLANK;
            done_q  <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE, FINISHED:
                begin
                    if (start_ok)
                    begin
                        state   <= COUNTING;
                        digit_q <= FIRST_DIGIT;
                        done_q  <= 1'b0;
                    end
                end
                COUNTING:
                begin
                    if (tick)
                    begin
                        digit_q <= digit_q - 1'b1;
                        // last step lands on zero
                        if (digit_q == 3'd1)
                        begin
                            state  <= FINISHED;
                            done_q <= 1'b1;
                        end
                    end
                end
                default:
                begin
                    state   <= IDLE;
                    digit_q <= DIGIT_BLANK;
                    done_q  <= 1'b0;
                end
            endcase
        end
    end

    assign status.digit = digit_q;
    assign status.done  = done_q;

endmodule

`default_nettype wire

// ==== src/step_tick.sv ====
`timescale 1ns/1ns
`default_nettype none

module step_tick #(
    parameter int TICKS_PER_STEP = 1000
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic tick
);

    localparam int CNT_W = $clog2(TICKS_PER_STEP + 1);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICKS_PER_STEP - 1);

    logic [CNT_W-1:0] cnt;

    // down-counter; start realigns the step boundary
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (start)
        begin
            cnt  <= RELOAD;
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= RELOAD;
            tick <= 1'b1;   // one cycle per period
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/timer_pkg.sv ====
`default_nettype none

package timer_pkg;

    // countdown controller states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        COUNTING = 2'd1,
        FINISHED = 2'd2
    } ctrl_state_t;

    // what the controller reports to the top level
    typedef struct packed {
        matrix_pkg::digit_t digit;
        logic               done;   // level, high from zero until restart
    } timer_status_t;

endpackage

`default_nettype wire

// ==== src/matrix_pkg.sv ====
`default_nettype none

package matrix_pkg;

    // 8x8 two-colour panel
    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 8;

    typedef logic [MATRIX_ROWS-1:0] row_t;   // active low, one bit per row
    typedef logic [MATRIX_COLS-1:0] col_t;   // active high, one colour
    typedef logic [2:0] row_idx_t;

    // 0..5 are glyphs, 6 and 7 are dark
    typedef logic [2:0] digit_t;

    localparam digit_t DIGIT_BLANK = 3'd7;

    // one scanned word of the panel
    typedef struct packed {
        row_t row;
        col_t colr;
        col_t colg;
    } matrix_drive_t;

endpackage

`default_nettype wire
